// ==== list.f ====
verilog/spi_flash_pkg.sv
verilog/flash_req_if.sv
verilog/flash_regs.sv
verilog/cache_read_port.sv
verilog/flash_req_arbiter.sv
verilog/spi_flash_shifter.sv
verilog/spi_flash_top.sv
testbench/flash_model.sv
testbench/tb_spi_flash.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/10ps -f list.f \
    --top-module tb_spi_flash -o tb_spi_flash \
  && { ./obj_dir/tb_spi_flash > sim.log 2>&1; cat sim.log; } \
  || { echo "Build failed"; exit 1; }

grep -q "Errors found" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "No errors" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

// ==== testbench/tb_spi_flash.sv ====
`timescale 1ns/10ps

module tb_spi_flash import spi_flash_pkg::*; ();

  localparam logic [23:0] FLASH_ID = 24'hC22817;
  // Longest frame is fast read, plus setup and register polling
  localparam int FRAME_CLKS  = 2 * CLKS_PER_HALF_SCLK * (8 + ADDR_W + FAST_READ_DUMMY + DATA_W) + 20;
  localparam int NUM_CMDS    = 11;
  localparam int WATCHDOG_NS = 2 * NUM_CMDS * FRAME_CLKS * 10;

  logic        clk;
  logic        rst;
  logic        reg_wr;
  logic        reg_rd;
  logic [2:0]  reg_idx;
  logic [31:0] reg_wdata;
  logic [31:0] reg_rdata;
  logic        cache_req;
  logic [23:0] cache_addr;
  logic        cache_ack;
  logic [31:0] cache_rdata;
  logic        sclk;
  logic        ss_n;
  logic        mosi;
  logic        miso;
  logic [15:0] lfsr;
  logic [7:0]  shadow [256]; // Expected flash contents
  time         cache_end_t;

  spi_flash_top dut0 (.*);

  flash_model #(.ID(FLASH_ID)) mdl0 (.sclk(sclk), .ss_n(ss_n), .mosi(mosi), .miso(miso));

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic logic [31:0] expected_word(input logic [23:0] addr);
    logic [31:0] w;
    w = '0;
    for (int k = 0; k < 4; k++)
      w = {w[23:0], shadow[addr[7:0] + 8'(k)]}; // First byte lands in the MSB
    return w;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
      $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("Errors found");
      $fatal(1, "Check failed");
    end
  endtask

  task automatic reg_write(input logic [2:0] idx, input logic [31:0] data);
    @(negedge clk);
    reg_wr    = 1'b1;
    reg_idx   = idx;
    reg_wdata = data;
    @(negedge clk);
    reg_wr = 1'b0;
  endtask

  task automatic reg_read(input logic [2:0] idx, output logic [31:0] data);
    @(negedge clk);
    reg_rd  = 1'b1;
    reg_idx = idx;
    @(negedge clk);
    data   = reg_rdata;
    reg_rd = 1'b0;
  endtask

  task automatic start_cmd(input flash_op_e op, input logic [5:0] nbits);
    reg_write(REG_CMD, {18'd0, nbits, op});
  endtask

  task automatic wait_done(output time t);
    logic [31:0] status;
    status = '0;
    while (!status[1])
      reg_read(REG_STATUS, status);
    t = $time;
  endtask

  task automatic run_cmd(input flash_op_e op, input logic [5:0] nbits, output logic [31:0] rdata);
    logic [31:0] status;
    time         t;
    start_cmd(op, nbits);
    wait_done(t);
    reg_read(REG_STATUS, status);
    check_value(status, 32'h2, "STATUS after command");
    reg_read(REG_RDATA, rdata);
  endtask

  task automatic cache_read(input logic [23:0] addr, output logic [31:0] data);
    @(negedge clk);
    cache_req  = 1'b1;
    cache_addr = addr;
    @(negedge clk);
    while (!cache_ack)
      @(negedge clk);
    data      = cache_rdata;
    cache_req = 1'b0;
    @(negedge clk);
    check_value({31'd0, cache_ack}, 32'd0, "cache_ack after cache_req drop");
    cache_end_t = $time;
  endtask

  task automatic test_read_id();
    logic [31:0] d;
    run_cmd(OP_READ_ID, 6'd24, d);
    check_value(d, {8'h00, FLASH_ID}, "read ID");
  endtask

  task automatic test_read();
    logic [31:0] a;
    logic [31:0] d;
    rand_bits(24, a);
    reg_write(REG_ADDR, a);
    run_cmd(OP_READ, 6'd32, d);
    check_value(d, expected_word(a[23:0]), "read word");
  endtask

  task automatic test_program();
    logic [31:0] a;
    logic [31:0] w;
    logic [31:0] d;
    rand_bits(24, a);
    rand_bits(32, w);
    reg_write(REG_ADDR, a);
    run_cmd(OP_WREN, 6'd0, d);
    reg_write(REG_WDATA, w);
    run_cmd(OP_PROGRAM, 6'd32, d);
    for (int k = 0; k < 4; k++)
      shadow[a[7:0] + 8'(k)] = w[31 - 8 * k -: 8];
    run_cmd(OP_READ, 6'd32, d);
    check_value(d, w, "read back after program");
    a = a + 32'h80; // Program without write enable must not land
    rand_bits(32, w);
    reg_write(REG_ADDR, a);
    reg_write(REG_WDATA, w);
    run_cmd(OP_PROGRAM, 6'd32, d);
    run_cmd(OP_READ, 6'd32, d);
    check_value(d, expected_word(a[23:0]), "memory after program without WREN");
  endtask

  task automatic test_cache_read();
    logic [31:0] a;
    logic [31:0] d;
    rand_bits(24, a);
    cache_read(a[23:0], d);
    check_value(d, expected_word(a[23:0]), "cache read word");
  endtask

  task automatic test_concurrent();
    logic [31:0] a_reg;
    logic [31:0] a_cache;
    logic [31:0] d_cache;
    logic [31:0] d;
    time         reg_done_t;
    rand_bits(24, a_reg);
    rand_bits(24, a_cache);
    reg_write(REG_ADDR, a_reg);
    fork
      cache_read(a_cache[23:0], d_cache);
      begin
        start_cmd(OP_READ, 6'd32);
        wait_done(reg_done_t);
      end
    join
    check_value(d_cache, expected_word(a_cache[23:0]), "concurrent cache word");
    check_value({31'd0, reg_done_t > cache_end_t}, 32'd1, "done before cache handshake end");
    reg_read(REG_RDATA, d);
    check_value(d, expected_word(a_reg[23:0]), "concurrent register word");
  endtask

  task automatic test_ignored_start();
    logic [31:0] a1;
    logic [31:0] a2;
    logic [31:0] d;
    time         t;
    rand_bits(24, a1);
    rand_bits(24, a2);
    reg_write(REG_ADDR, a1);
    start_cmd(OP_READ, 6'd32);
    reg_write(REG_ADDR, a2);       // Busy, dropped
    start_cmd(OP_READ_ID, 6'd24);  // Busy, dropped
    wait_done(t);
    reg_read(REG_RDATA, d);
    check_value(d, expected_word(a1[23:0]), "result after ignored start");
    reg_read(REG_CMD, d);
    check_value(d, {18'd0, 6'd32, OP_READ}, "CMD register after ignored start");
    repeat (40) @(negedge clk);
    reg_read(REG_STATUS, d);
    check_value(d, 32'h2, "STATUS long after ignored start");
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    logic [31:0] status;
    rst        = 1'b1;
    reg_wr     = 1'b0;
    reg_rd     = 1'b0;
    reg_idx    = '0;
    reg_wdata  = '0;
    cache_req  = 1'b0;
    cache_addr = '0;
    lfsr       = 16'd36;
    for (int i = 0; i < 256; i++)
      shadow[8'(i)] = 8'(i) ^ 8'hA5;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    check_value({28'd0, ss_n, sclk, mosi, cache_ack}, 32'h8, "pins after reset");
    reg_read(REG_STATUS, status);
    check_value(status, 32'h0, "STATUS after reset");
    test_read_id();
    test_read();
    test_program();
    test_cache_read();
    test_concurrent();
    test_ignored_start();
    $display("No errors");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: tests still running after %0d ns", WATCHDOG_NS);
    $display("Errors found");
    $fatal(1, "Watchdog expired");
  end

endmodule

// ==== testbench/flash_model.sv ====
`timescale 1ns/10ps

module flash_model import spi_flash_pkg::*; #(
  parameter logic [23:0] ID = 24'hC22817
) (
  input  logic sclk,
  input  logic ss_n,
  input  logic mosi,
  output logic miso
);

  logic [7:0]  mem [256];
  logic [7:0]  sr;
  logic [7:0]  op;
  logic [7:0]  addr;
  logic [7:0]  cur_byte;
  logic [2:0]  bit_pos;
  logic        wel;
  logic        rd_op;
  int          cnt;
  int          data_start;
  int          idx;

  initial begin
    for (int i = 0; i < 256; i++)
      mem[8'(i)] = 8'(i) ^ 8'hA5; // Byte equals address XOR A5h
    op         = '0;
    rd_op      = 1'b0;
    wel        = 1'b0;
    miso       = 1'b0;
    cnt        = 0;
    data_start = 0;
  end

  always @(posedge sclk or posedge ss_n) begin
    if (ss_n) begin
      if (op == OP_WREN && cnt == 8)
        wel = 1'b1;
      else if (op == OP_PROGRAM && cnt >= 32)
        wel = 1'b0; // Program consumes the latch
      op    = '0;
      rd_op = 1'b0;
      cnt   = 0;
    end else begin
      sr  = {sr[6:0], mosi};
      cnt = cnt + 1;
      if (cnt == 8) begin
        op         = sr[7:0];
        rd_op      = (op == OP_READ) || (op == OP_FAST_READ) || (op == OP_READ_ID);
        data_start = (op == OP_READ_ID) ? 8 : ((op == OP_FAST_READ) ? 40 : 32);
      end
      if (cnt == 32)
        addr = sr[7:0]; // Upper address bits ignored by the 256-byte array
      if (op == OP_PROGRAM && cnt > 32 && cnt % 8 == 0) begin
        if (wel)
          mem[addr] = sr[7:0];
        addr = addr + 8'd1;
      end
      if (rd_op && cnt >= data_start && (cnt - data_start) % 8 == 0) begin
        if (op == OP_READ_ID) begin
          idx      = (cnt - 8) / 8;
          cur_byte = (idx < 3) ? 8'(ID >> (8 * (2 - idx))) : 8'h00;
        end else begin
          cur_byte = mem[addr];
          addr     = addr + 8'd1;
        end
      end
    end
  end

  // Mode 0 puts the next bit out on the falling edge
  always @(negedge sclk) begin
    if (!ss_n && rd_op && cnt >= data_start) begin
      bit_pos = 3'(cnt - data_start);
      miso <= cur_byte[3'd7 - bit_pos];
    end
  end

endmodule

// ==== verilog/spi_flash_top.sv ====
`timescale 1ns/10ps

module spi_flash_top import spi_flash_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              reg_wr,
  input  logic              reg_rd,
  input  logic [2:0]        reg_idx,
  input  logic [DATA_W-1:0] reg_wdata,
  output logic [DATA_W-1:0] reg_rdata,
  input  logic              cache_req,
  input  logic [ADDR_W-1:0] cache_addr,
  output logic              cache_ack,
  output logic [DATA_W-1:0] cache_rdata,
  output logic              sclk,
  output logic              ss_n,
  output logic              mosi,
  input  logic              miso
);

  flash_req_if reg_ch ();
  flash_req_if cache_ch ();
  flash_req_if spi_ch ();

  flash_regs regs0 (
    .clk       (clk),
    .rst       (rst),
    .reg_wr    (reg_wr),
    .reg_rd    (reg_rd),
    .reg_idx   (reg_idx),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .ch        (reg_ch.client)
  );

  cache_read_port cport0 (
    .clk         (clk),
    .rst         (rst),
    .cache_req   (cache_req),
    .cache_addr  (cache_addr),
    .cache_ack   (cache_ack),
    .cache_rdata (cache_rdata),
    .ch          (cache_ch.client)
  );

  flash_req_arbiter arb0 (
    .clk      (clk),
    .rst      (rst),
    .reg_ch   (reg_ch.server),
    .cache_ch (cache_ch.server),
    .spi_ch   (spi_ch.client)
  );

  spi_flash_shifter shift0 (
    .clk  (clk),
    .rst  (rst),
    .ch   (spi_ch.server),
    .sclk (sclk),
    .ss_n (ss_n),
    .mosi (mosi),
    .miso (miso)
  );

endmodule

// ==== verilog/spi_flash_shifter.sv ====
`timescale 1ns/10ps

module spi_flash_shifter import spi_flash_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  flash_req_if.server ch,
  output logic        sclk,
  output logic        ss_n,
  output logic        mosi,
  input  logic        miso
);

  shift_state_e state;
  shift_state_e nxt;
  logic [$clog2(CLKS_PER_HALF_SCLK+1)-1:0] hcnt;
  logic [NBITS_W-1:0] bit_cnt;
  logic [NBITS_W-1:0] load_cnt;
  logic [DATA_W-1:0]  load_val;
  logic [DATA_W-1:0]  sh_q;
  logic [DATA_W-1:0]  rx_q;
  logic [DATA_W-1:0]  wdata_al;
  flash_op_e          op_q;
  logic [ADDR_W-1:0]  addr_q;
  logic [NBITS_W-1:0] nbits_q;
  logic [DATA_W-1:0]  wdata_q;
  logic has_addr, has_dummy, data_in, data_out;
  logic start, active, tick, rise, fall;

  // Frame shape from the opcode
  assign has_addr  = op_q inside {OP_READ, OP_FAST_READ, OP_PROGRAM};
  assign has_dummy = (op_q == OP_FAST_READ);
  assign data_in   = op_q inside {OP_READ, OP_FAST_READ, OP_READ_ID};
  assign data_out  = (op_q == OP_PROGRAM);

  assign start    = (state == S_IDLE) && ch.req && !ch.ack;
  assign active   = (state != S_IDLE) && (state != S_DONE);
  assign tick     = (hcnt == CLKS_PER_HALF_SCLK - 1);
  assign rise     = active && tick && !sclk;
  assign fall     = active && tick && sclk;
  assign wdata_al = wdata_q << (DATA_W - nbits_q); // MSB first
  assign ch.rdata = rx_q;

  // Phase that follows the current one and its first shift word
  always_comb begin
    case (state)
      S_OPCODE: nxt = has_addr ? S_ADDR : ((data_in || data_out) ? S_DATA : S_DONE);
      S_ADDR:   nxt = has_dummy ? S_DUMMY : S_DATA;
      S_DUMMY:  nxt = S_DATA;
      default:  nxt = S_DONE;
    endcase
    load_val = '0;
    load_cnt = '0;
    case (nxt)
      S_ADDR: begin
        load_val = {addr_q, {(DATA_W-ADDR_W){1'b0}}};
        load_cnt = NBITS_W'(ADDR_W - 1);
      end
      S_DUMMY: load_cnt = NBITS_W'(FAST_READ_DUMMY - 1);
      S_DATA: begin
        load_val = data_out ? wdata_al : '0;
        load_cnt = nbits_q - 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= S_IDLE;
      hcnt    <= '0;
      bit_cnt <= '0;
      sclk    <= 1'b0;
      ss_n    <= 1'b1;
      mosi    <= 1'b0;
      ch.ack  <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            state   <= S_OPCODE;
            ss_n    <= 1'b0;
            mosi    <= ch.op[7]; // First bit set up before the first rise
            bit_cnt <= NBITS_W'(7);
            hcnt    <= '0;
          end
        end
        S_DONE: begin
          if (!ch.req) begin
            ch.ack <= 1'b0;
            state  <= S_IDLE;
          end
        end
        default: begin
          hcnt <= tick ? '0 : hcnt + 1'b1;
          if (tick)
            sclk <= ~sclk;
          if (fall) begin
            if (bit_cnt != 0) begin
              bit_cnt <= bit_cnt - 1'b1;
              mosi    <= sh_q[DATA_W-2];
            end else begin
              state   <= nxt;
              bit_cnt <= load_cnt;
              mosi    <= load_val[DATA_W-1];
              if (nxt == S_DONE) begin
                ss_n   <= 1'b1;
                ch.ack <= 1'b1;
              end
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      op_q    <= ch.op;
      addr_q  <= ch.addr;
      nbits_q <= ch.nbits;
      wdata_q <= ch.wdata;
      sh_q    <= {ch.op, {(DATA_W-8){1'b0}}};
      rx_q    <= '0;
    end else if (fall) begin
      sh_q <= (bit_cnt != 0) ? (sh_q << 1) : load_val;
    end
    if (rise && (state == S_DATA) && data_in)
      rx_q <= {rx_q[DATA_W-2:0], miso}; // Sample on rising SCLK
  end

endmodule

// ==== verilog/flash_req_arbiter.sv ====
`timescale 1ns/10ps

module flash_req_arbiter import spi_flash_pkg::*; (
  input logic         clk,
  input logic         rst,
  flash_req_if.server reg_ch,
  flash_req_if.server cache_ch,
  flash_req_if.client spi_ch
);

  logic [1:0]        grant;
  logic              ack_q;
  logic [DATA_W-1:0] rdata_q;
  logic              spi_idle;

  assign spi_idle = !spi_ch.req && !spi_ch.ack;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      grant <= GNT_NONE;
      ack_q <= 1'b0;
    end else begin
      ack_q <= spi_ch.ack;
      case (grant)
        GNT_NONE: begin
          if (spi_idle && cache_ch.req)
            grant <= GNT_CACHE; // Cache wins ties
          else if (spi_idle && reg_ch.req)
            grant <= GNT_REG;
        end
        GNT_REG: begin
          if (!reg_ch.req && !reg_ch.ack)
            grant <= GNT_NONE;
        end
        GNT_CACHE: begin
          if (!cache_ch.req && !cache_ch.ack)
            grant <= GNT_NONE;
        end
        default: grant <= GNT_NONE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    rdata_q <= spi_ch.rdata;
  end

  always_comb begin
    spi_ch.req   = 1'b0;
    spi_ch.op    = OP_READ;
    spi_ch.addr  = '0;
    spi_ch.nbits = '0;
    spi_ch.wdata = '0;
    if (grant == GNT_CACHE) begin
      spi_ch.req   = cache_ch.req;
      spi_ch.op    = cache_ch.op;
      spi_ch.addr  = cache_ch.addr;
      spi_ch.nbits = cache_ch.nbits;
      spi_ch.wdata = cache_ch.wdata;
    end else if (grant == GNT_REG) begin
      spi_ch.req   = reg_ch.req;
      spi_ch.op    = reg_ch.op;
      spi_ch.addr  = reg_ch.addr;
      spi_ch.nbits = reg_ch.nbits;
      spi_ch.wdata = reg_ch.wdata;
    end
  end

  assign reg_ch.ack     = (grant == GNT_REG) && ack_q;
  assign reg_ch.rdata   = (grant == GNT_REG) ? rdata_q : '0;
  assign cache_ch.ack   = (grant == GNT_CACHE) && ack_q;
  assign cache_ch.rdata = (grant == GNT_CACHE) ? rdata_q : '0;

endmodule

// ==== verilog/cache_read_port.sv ====
`timescale 1ns/10ps

module cache_read_port import spi_flash_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              cache_req,
  input  logic [ADDR_W-1:0] cache_addr,
  output logic              cache_ack,
  output logic [DATA_W-1:0] cache_rdata,
  flash_req_if.client       ch
);

  logic              req_q;
  logic              start;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] rdata_q;

  // New request only once the previous internal handshake has closed
  assign start = cache_req && !req_q && !ch.ack;

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      req_q <= 1'b0;
    else if (start)
      req_q <= 1'b1;
    else if (!cache_req)
      req_q <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (start)
      addr_q <= cache_addr;
    if (ch.ack)
      rdata_q <= ch.rdata;
  end

  assign ch.req   = req_q;
  assign ch.op    = OP_FAST_READ;
  assign ch.addr  = addr_q;
  assign ch.nbits = NBITS_W'(DATA_W); // Always a full word
  assign ch.wdata = '0;

  assign cache_ack   = ch.ack && req_q; // Drops a cycle after cache_req
  assign cache_rdata = ch.ack ? ch.rdata : rdata_q;

endmodule

// ==== verilog/flash_regs.sv ====
`timescale 1ns/10ps

module flash_regs import spi_flash_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              reg_wr,
  input  logic              reg_rd,
  input  logic [2:0]        reg_idx,
  input  logic [DATA_W-1:0] reg_wdata,
  output logic [DATA_W-1:0] reg_rdata,
  flash_req_if.client       ch
);

  flash_op_e          op_q;
  logic [NBITS_W-1:0] nbits_q;
  logic [ADDR_W-1:0]  addr_q;
  logic [DATA_W-1:0]  wdata_q;
  logic [DATA_W-1:0]  rdata_q;
  logic               busy;
  logic               done;
  logic               req_q;
  logic               wr_ok;
  logic               cmd_start;

  assign wr_ok     = reg_wr && !busy; // Fields stay frozen during a command
  assign cmd_start = wr_ok && (reg_idx == REG_CMD);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy  <= 1'b0;
      done  <= 1'b0;
      req_q <= 1'b0;
    end else if (cmd_start) begin
      busy  <= 1'b1;
      done  <= 1'b0;
      req_q <= 1'b1;
    end else if (req_q && ch.ack) begin
      req_q <= 1'b0;
    end else if (busy && !req_q && !ch.ack) begin
      busy <= 1'b0; // Handshake fully closed
      done <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      case (reg_idx)
        REG_CMD: begin
          op_q    <= flash_op_e'(reg_wdata[7:0]);
          nbits_q <= reg_wdata[13:8];
        end
        REG_ADDR:  addr_q  <= reg_wdata[ADDR_W-1:0];
        REG_WDATA: wdata_q <= reg_wdata;
        default: ;
      endcase
    end
    if (req_q && ch.ack)
      rdata_q <= ch.rdata;
  end

  assign ch.req   = req_q;
  assign ch.op    = op_q;
  assign ch.addr  = addr_q;
  assign ch.nbits = nbits_q;
  assign ch.wdata = wdata_q;

  // Read data is driven only while reg_rd is high
  always_comb begin
    reg_rdata = '0;
    if (reg_rd) begin
      case (reg_idx)
        REG_CMD:    reg_rdata = {18'd0, nbits_q, op_q};
        REG_ADDR:   reg_rdata = {{(DATA_W-ADDR_W){1'b0}}, addr_q};
        REG_WDATA:  reg_rdata = wdata_q;
        REG_RDATA:  reg_rdata = rdata_q;
        REG_STATUS: reg_rdata = {30'd0, done, busy};
        default:    reg_rdata = '0;
      endcase
    end
  end

endmodule

// ==== verilog/flash_req_if.sv ====
`timescale 1ns/10ps

interface flash_req_if import spi_flash_pkg::*; ();

  logic               req;
  logic               ack;
  flash_op_e          op;
  logic [ADDR_W-1:0]  addr;
  logic [NBITS_W-1:0] nbits; // Data phase length in bits
  logic [DATA_W-1:0]  wdata;
  logic [DATA_W-1:0]  rdata; // Right aligned, valid with ack

  modport client (
    output req, op, addr, nbits, wdata,
    input  ack, rdata
  );

  modport server (
    input  req, op, addr, nbits, wdata,
    output ack, rdata
  );

endinterface

// ==== verilog/spi_flash_pkg.sv ====
package spi_flash_pkg;

  // Flash opcodes, single line only
  typedef enum logic [7:0] {
    OP_PROGRAM   = 8'h02,
    OP_READ      = 8'h03,
    OP_WREN      = 8'h06,
    OP_FAST_READ = 8'h0B,
    OP_READ_ID   = 8'h9F
  } flash_op_e;

  typedef enum logic [2:0] {
    S_IDLE,
    S_OPCODE,
    S_ADDR,
    S_DUMMY,
    S_DATA,
    S_DONE
  } shift_state_e;

  localparam int ADDR_W             = 24;
  localparam int DATA_W             = 32;
  localparam int NBITS_W            = 6;
  localparam int CLKS_PER_HALF_SCLK = 2;
  localparam int FAST_READ_DUMMY    = 8; // SCLK cycles

  localparam logic [2:0] REG_CMD    = 3'd0;
  localparam logic [2:0] REG_ADDR   = 3'd1;
  localparam logic [2:0] REG_WDATA  = 3'd2;
  localparam logic [2:0] REG_RDATA  = 3'd3;
  localparam logic [2:0] REG_STATUS = 3'd4;

  // Arbiter grant codes
  localparam logic [1:0] GNT_NONE  = 2'd0;
  localparam logic [1:0] GNT_REG   = 2'd1;
  localparam logic [1:0] GNT_CACHE = 2'd2;

endpackage
